//--- verilog/secded_pkg.sv
package secded_pkg;

  // Code geometry for the (39,32) Hsiao code
  localparam int data_width      = 32;
  localparam int parity_width    = 7;
  localparam int codeword_width  = parity_width + data_width;

  // Width of each saturating error counter
  localparam int log_count_width = 16;

  // Check-matrix column of each data bit, index 0 first
  // All distinct weight-3 columns, so never equal to a one-hot check column
  localparam logic [parity_width-1:0] hsiao_columns [data_width] = '{
    7'h07, 7'h0b, 7'h13, 7'h23, 7'h43,
    7'h0d, 7'h15, 7'h25, 7'h45,
    7'h19, 7'h29, 7'h49,
    7'h31, 7'h51,
    7'h61,
    7'h0e, 7'h16, 7'h26, 7'h46,
    7'h1a, 7'h2a, 7'h4a,
    7'h32, 7'h52,
    7'h62,
    7'h1c, 7'h2c, 7'h4c,
    7'h34, 7'h54,
    7'h64,
    7'h38
  };

  // Decode outcome
  typedef enum logic [1:0] {
    ecc_ok  = 2'd0,
    ecc_ce  = 2'd1,
    ecc_due = 2'd2
  } ecc_status_e;

  // Check bits sit above the data bits
  typedef struct packed {
    logic [parity_width-1:0] parity;
    logic [data_width-1:0]   data;
  } codeword_t;

  // Received word plus its syndrome, between the two decode stages
  typedef struct packed {
    codeword_t               codeword;
    logic [parity_width-1:0] syndrome;
  } syndrome_word_t;

  // Decoder output, also consumed by the error log
  typedef struct packed {
    logic [data_width-1:0]   data;
    ecc_status_e             status;
    logic [parity_width-1:0] syndrome;
  } dec_result_t;

  // Check bit j is the parity of the data bits whose column has bit j set
  function automatic logic [parity_width-1:0] calc_parity(
    input logic [data_width-1:0] d
  );
    logic [parity_width-1:0] p;
    logic [data_width-1:0]   row;
    p = '0;
    for (int j = 0; j < parity_width; j++) begin
      // Row j of the check matrix, gathered across columns
      for (int i = 0; i < data_width; i++) begin
        row[i] = hsiao_columns[i][j];
      end
      p[j] = ^(d & row);
    end
    return p;
  endfunction

endpackage

//--- verilog/secded_encoder.sv
`timescale 1ns/1ps

module secded_encoder (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            data_valid,
  input  logic [secded_pkg::data_width-1:0] data,
  output logic                            enc_valid,
  output secded_pkg::codeword_t           enc_codeword
);

  import secded_pkg::*;

  // Check bits for the incoming word
  logic [parity_width-1:0] check_bits;

  // Codeword before the output register
  codeword_t               next_codeword;

  // XOR reduction per check bit over the column table
  always_comb begin
    check_bits = calc_parity(data);
  end

  // Parity field above data field
  always_comb begin
    next_codeword.parity = check_bits;
    next_codeword.data   = data;
  end

  // Strobe follows data_valid by one cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      enc_valid <= 1'b0;
    end else begin
      enc_valid <= data_valid;
    end
  end

  // Codeword register
  // Holds its value between strobes
  always_ff @(posedge clk) begin
    if (data_valid) begin
      enc_codeword <= next_codeword;
    end
  end

endmodule

//--- verilog/secded_syndrome.sv
`timescale 1ns/1ps

module secded_syndrome (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       rcv_valid,
  input  secded_pkg::codeword_t      rcv_codeword,
  output logic                       syn_valid,
  output secded_pkg::syndrome_word_t syn_word
);

  import secded_pkg::*;

  // Check bits rebuilt from the received data field
  logic [parity_width-1:0] recomputed;

  // Nonzero when the word was disturbed
  logic [parity_width-1:0] syndrome;

  // Next value of the stage register
  syndrome_word_t          next_word;

  // Reduction tree, the long path of the decoder
  always_comb begin
    recomputed = calc_parity(rcv_codeword.data);
    syndrome   = recomputed ^ rcv_codeword.parity;
  end

  // Keep the received word next to its syndrome
  always_comb begin
    next_word.codeword = rcv_codeword;
    next_word.syndrome = syndrome;
  end

  // One cycle through this stage
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      syn_valid <= 1'b0;
    end else begin
      syn_valid <= rcv_valid;
    end
  end

  // Payload register, loads only on a valid word
  always_ff @(posedge clk) begin
    if (rcv_valid) begin
      syn_word <= next_word;
    end
  end

endmodule

//--- verilog/secded_corrector.sv
`timescale 1ns/1ps

module secded_corrector (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       syn_valid,
  input  secded_pkg::syndrome_word_t syn_word,
  output logic                       dec_valid,
  output secded_pkg::dec_result_t    dec_result
);

  import secded_pkg::*;

  // Syndrome of the word in this stage
  logic [parity_width-1:0] syndrome;

  // One bit per data position, set where the column equals the syndrome
  logic [data_width-1:0]   flip_mask;

  // Syndrome properties
  logic                    any_match;
  logic                    is_zero;
  logic                    is_onehot;
  logic                    odd_weight;

  // Classified result before the output register
  ecc_status_e             status;
  dec_result_t             next_result;

  assign syndrome = syn_word.syndrome;

  // Compare against every data column
  always_comb begin
    for (int i = 0; i < data_width; i++) begin
      flip_mask[i] = (syndrome == hsiao_columns[i]);
    end
  end

  always_comb begin
    any_match  = |flip_mask;
    is_zero    = (syndrome == '0);
    is_onehot  = $onehot(syndrome);
    odd_weight = ^syndrome;
  end

  // Even nonzero weight means two flips
  // Odd weight with no column match is three or more
  always_comb begin
    if (is_zero) begin
      status = ecc_ok;
    end else if (odd_weight && (any_match || is_onehot)) begin
      status = ecc_ce;
    end else begin
      status = ecc_due;
    end
  end

  // Only a data column match flips a bit
  // Check-bit errors and uncorrectable words pass the data unchanged
  always_comb begin
    next_result.data     = syn_word.codeword.data ^
                           ((status == ecc_ce) ? flip_mask : '0);
    next_result.status   = status;
    next_result.syndrome = syndrome;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      dec_valid <= 1'b0;
    end else begin
      dec_valid <= syn_valid;
    end
  end

  // Result register
  always_ff @(posedge clk) begin
    if (syn_valid) begin
      dec_result <= next_result;
    end
  end

endmodule

//--- verilog/ecc_error_log.sv
`timescale 1ns/1ps

module ecc_error_log (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  log_clear,
  input  logic                                  dec_valid,
  input  secded_pkg::dec_result_t               dec_result,
  output logic [secded_pkg::log_count_width-1:0] ce_count,
  output logic [secded_pkg::log_count_width-1:0] due_count,
  output logic                                  first_err_valid,
  output logic [secded_pkg::parity_width-1:0]   first_err_syndrome
);

  import secded_pkg::*;

  // Event qualifiers for this cycle
  logic ce_event;
  logic due_event;

  assign ce_event  = dec_valid && (dec_result.status == ecc_ce);
  assign due_event = dec_valid && (dec_result.status == ecc_due);

  // Counters stop at all ones
  always_ff @(posedge clk) begin
    if (!rst_n || log_clear) begin
      ce_count  <= '0;
      due_count <= '0;
    end else begin
      if (ce_event && (ce_count != '1)) begin
        ce_count <= ce_count + 1'b1;
      end
      if (due_event && (due_count != '1)) begin
        due_count <= due_count + 1'b1;
      end
    end
  end

  // First error capture
  // Sticky until the next clear, later errors are ignored
  always_ff @(posedge clk) begin
    if (!rst_n || log_clear) begin
      first_err_valid    <= 1'b0;
      first_err_syndrome <= '0;
    end else if ((ce_event || due_event) && !first_err_valid) begin
      first_err_valid    <= 1'b1;
      first_err_syndrome <= dec_result.syndrome;
    end
  end

endmodule

//--- verilog/secded_top.sv
`timescale 1ns/1ps

module secded_top (
  input  logic                                  clk,
  input  logic                                  rst_n,
  // Encode path
  input  logic                                  data_valid,
  input  logic [secded_pkg::data_width-1:0]     data,
  output logic                                  enc_valid,
  output secded_pkg::codeword_t                 enc_codeword,
  // Decode path
  input  logic                                  rcv_valid,
  input  secded_pkg::codeword_t                 rcv_codeword,
  output logic                                  dec_valid,
  output secded_pkg::dec_result_t               dec_result,
  // Error log
  input  logic                                  log_clear,
  output logic [secded_pkg::log_count_width-1:0] ce_count,
  output logic [secded_pkg::log_count_width-1:0] due_count,
  output logic                                  first_err_valid,
  output logic [secded_pkg::parity_width-1:0]   first_err_syndrome
);

  import secded_pkg::*;

  // Between syndrome and correction stages
  logic           syn_valid;
  syndrome_word_t syn_word;

  secded_encoder i_encoder (
    .clk,
    .rst_n,
    .data_valid,
    .data,
    .enc_valid,
    .enc_codeword
  );

  // Two-cycle decoder
  secded_syndrome i_syndrome (
    .clk,
    .rst_n,
    .rcv_valid,
    .rcv_codeword,
    .syn_valid,
    .syn_word
  );

  secded_corrector i_corrector (
    .clk,
    .rst_n,
    .syn_valid,
    .syn_word,
    .dec_valid,
    .dec_result
  );

  // Watches the decoder output
  ecc_error_log i_error_log (
    .clk,
    .rst_n,
    .log_clear,
    .dec_valid,
    .dec_result,
    .ce_count,
    .due_count,
    .first_err_valid,
    .first_err_syndrome
  );

endmodule

//--- tests/secded_tb.sv
`timescale 1ns/1ps

module secded_tb;

  import secded_pkg::*;

  localparam int max_cases  = 64;
  localparam int rand_cases = 8;

  // Expected encoder output, due is the cycle count it must show up at
  typedef struct packed {
    logic [31:0]               due;
    logic                      loopback;
    logic [codeword_width-1:0] codeword;
  } enc_exp_t;

  // Expected decoder output
  typedef struct packed {
    logic [31:0]             due;
    logic                    check_data;
    logic [parity_width-1:0] syndrome;
    logic [data_width-1:0]   data;
    ecc_status_e             status;
  } dec_exp_t;

  logic                       clk = 1'b0;
  logic                       rst_n;
  logic                       data_valid;
  logic [data_width-1:0]      data;
  logic                       enc_valid;
  codeword_t                  enc_codeword;
  logic                       rcv_valid;
  codeword_t                  rcv_codeword;
  logic                       dec_valid;
  dec_result_t                dec_result;
  logic                       log_clear;
  logic [log_count_width-1:0] ce_count;
  logic [log_count_width-1:0] due_count;
  logic                       first_err_valid;
  logic [parity_width-1:0]    first_err_syndrome;

  // Four tokens per case: data, check bits, flip mask, status
  logic [39:0] case_mem [0:4*max_cases-1];

  // Words in flight, oldest first
  enc_exp_t  enc_q[$];
  dec_exp_t  dec_q[$];
  // Encoded random words waiting to be fed back
  codeword_t loop_q[$];
  // Random data words as sent
  logic [data_width-1:0] sent_q[$];

  int unsigned                cycle = 0;
  int unsigned                limit = 0;
  int                         stream_errors = 0;
  int                         run_errors = 0;
  int                         num_cases = 0;
  logic [log_count_width-1:0] exp_ce = '0;
  logic [log_count_width-1:0] exp_due = '0;
  logic                       seen_err = 1'b0;
  logic [parity_width-1:0]    first_syn = '0;

  secded_top i_dut (
    .clk,
    .rst_n,
    .data_valid,
    .data,
    .enc_valid,
    .enc_codeword,
    .rcv_valid,
    .rcv_codeword,
    .dec_valid,
    .dec_result,
    .log_clear,
    .ce_count,
    .due_count,
    .first_err_valid,
    .first_err_syndrome
  );

  // 100 ns period
  always #50 clk = ~clk;

  // Cycle count and watchdog
  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= limit) begin
      $display("Timeout: the run was still going after %0d cycles", cycle);
      $display("Verification failed");
      $finish;
    end
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // Syndrome caused by a flip mask on a clean codeword
  function automatic logic [parity_width-1:0] flip_syndrome(
    input logic [codeword_width-1:0] mask
  );
    logic [parity_width-1:0] s;
    // Flipped check bits show up as themselves
    s = mask[codeword_width-1:data_width];
    // Each flipped data bit adds its own column
    for (int i = 0; i < data_width; i++) begin
      if (mask[i]) begin
        s = s ^ hsiao_columns[i];
      end
    end
    return s;
  endfunction

  // Drives one file case into both paths in the same cycle
  task automatic drive_case(input int idx);
    logic [data_width-1:0]     d;
    logic [parity_width-1:0]   p;
    logic [codeword_width-1:0] mask;
    enc_exp_t                  ee;
    dec_exp_t                  de;
    d    = case_mem[4*idx][data_width-1:0];
    p    = case_mem[4*idx+1][parity_width-1:0];
    mask = case_mem[4*idx+2][codeword_width-1:0];
    ee.due      = cycle + 2;
    ee.loopback = 1'b0;
    ee.codeword = {p, d};
    de.due      = cycle + 3;
    de.status   = ecc_status_e'(case_mem[4*idx+3][1:0]);
    // Data of an uncorrectable word is not defined
    de.check_data = (de.status != ecc_due);
    de.data       = d;
    de.syndrome   = flip_syndrome(mask);
    enc_q.push_back(ee);
    dec_q.push_back(de);
    if (de.status == ecc_ce) begin
      exp_ce = exp_ce + 16'd1;
    end
    if (de.status == ecc_due) begin
      exp_due = exp_due + 16'd1;
    end
    data_valid   <= 1'b1;
    data         <= d;
    rcv_valid    <= 1'b1;
    rcv_codeword <= {p, d} ^ mask;
  endtask

  // Until both output streams are empty, then to a stable point
  task automatic wait_drained();
    while (enc_q.size() != 0 || dec_q.size() != 0) begin
      @(posedge clk);
    end
    @(negedge clk);
  endtask

  // Output checks, sampled mid-cycle
  always @(negedge clk) begin
    enc_exp_t ee;
    dec_exp_t de;
    if (enc_valid) begin
      if (enc_q.size() == 0) begin
        $display("enc_valid was high at cycle %0d with no word in flight", cycle);
        stream_errors++;
      end else begin
        ee = enc_q.pop_front();
        if (ee.due != cycle) begin
          $display("enc_valid came at cycle %0d, expected at cycle %0d", cycle, ee.due);
          stream_errors++;
        end
        if (ee.loopback) begin
          loop_q.push_back(enc_codeword);
          if (enc_codeword.data !== ee.codeword[data_width-1:0]) begin
            $display("Error: enc_codeword.data expected %h actual %h",
                     ee.codeword[data_width-1:0], enc_codeword.data);
            stream_errors++;
          end
        end else if (enc_codeword !== ee.codeword) begin
          $display("Error: enc_codeword expected %h actual %h", ee.codeword, enc_codeword);
          stream_errors++;
        end
      end
    end else if (enc_q.size() != 0 && enc_q[0].due == cycle) begin
      $display("enc_valid did not come at cycle %0d", cycle);
      stream_errors++;
      ee = enc_q.pop_front();
    end
    if (dec_valid) begin
      if (dec_q.size() == 0) begin
        $display("dec_valid was high at cycle %0d with no word in flight", cycle);
        stream_errors++;
      end else begin
        de = dec_q.pop_front();
        if (de.due != cycle) begin
          $display("dec_valid came at cycle %0d, expected at cycle %0d", cycle, de.due);
          stream_errors++;
        end
        if (dec_result.status !== de.status) begin
          $display("Error: dec_result.status expected %h actual %h",
                   de.status, dec_result.status);
          stream_errors++;
        end
        if (de.check_data && dec_result.data !== de.data) begin
          $display("Error: dec_result.data expected %h actual %h", de.data, dec_result.data);
          stream_errors++;
        end
        if (dec_result.syndrome !== de.syndrome) begin
          $display("Error: dec_result.syndrome expected %h actual %h",
                   de.syndrome, dec_result.syndrome);
          stream_errors++;
        end
        // Syndrome of the first bad word, for the log check
        if (!seen_err && de.status != ecc_ok) begin
          seen_err  = 1'b1;
          first_syn = de.syndrome;
        end
      end
    end else if (dec_q.size() != 0 && dec_q[0].due == cycle) begin
      $display("dec_valid did not come at cycle %0d", cycle);
      stream_errors++;
      de = dec_q.pop_front();
    end
  end

  initial begin
    logic [data_width-1:0] seed;
    codeword_t             cw;
    enc_exp_t              ee;
    dec_exp_t              de;
    rst_n        = 1'b0;
    data_valid   = 1'b0;
    data         = '0;
    rcv_valid    = 1'b0;
    rcv_codeword = '0;
    log_clear    = 1'b0;
    seed         = 32'h687c;
    // Unused entries carry ff in the top byte, above any token of the file
    for (int a = 0; a < 4*max_cases; a++) begin
      case_mem[a] = {8'hff, 32'(a)};
    end
    $readmemh("tests/secded_cases.txt", case_mem);
    // Case count is where the file runs out
    while (num_cases < max_cases && case_mem[4*num_cases][39:32] != 8'hff) begin
      num_cases++;
    end
    if (num_cases == 0) begin
      $display("No cases could be read from tests/secded_cases.txt");
      run_errors++;
    end
    limit = 16 + 4 * (num_cases + rand_cases) + 50;

    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    if (enc_valid !== 1'b0 || dec_valid !== 1'b0 || first_err_valid !== 1'b0) begin
      $display("A valid output was not low right after reset");
      run_errors++;
    end
    if (ce_count !== '0 || due_count !== '0) begin
      $display("Error: ce_count/due_count expected 0000/0000 actual %h/%h",
               ce_count, due_count);
      run_errors++;
    end

    // File cases, one per cycle
    for (int i = 0; i < num_cases; i++) begin
      @(posedge clk);
      drive_case(i);
    end
    @(posedge clk);
    data_valid <= 1'b0;
    rcv_valid  <= 1'b0;
    wait_drained();

    // Log, one cycle after the last result
    if (ce_count !== exp_ce) begin
      $display("Error: ce_count expected %h actual %h", exp_ce, ce_count);
      run_errors++;
    end
    if (due_count !== exp_due) begin
      $display("Error: due_count expected %h actual %h", exp_due, due_count);
      run_errors++;
    end
    if (first_err_valid !== seen_err) begin
      $display("Error: first_err_valid expected %h actual %h", seen_err, first_err_valid);
      run_errors++;
    end
    if (seen_err && first_err_syndrome !== first_syn) begin
      $display("Error: first_err_syndrome expected %h actual %h",
               first_syn, first_err_syndrome);
      run_errors++;
    end

    // Clear pulse
    @(posedge clk);
    log_clear <= 1'b1;
    @(posedge clk);
    log_clear <= 1'b0;
    @(negedge clk);
    if (ce_count !== '0 || due_count !== '0 || first_err_valid !== 1'b0) begin
      $display("The error log was not empty after log_clear");
      run_errors++;
    end

    // Random words through the encoder
    for (int k = 0; k < rand_cases; k++) begin
      @(posedge clk);
      seed        = lcg_next(seed);
      ee.due      = cycle + 2;
      ee.loopback = 1'b1;
      ee.codeword = {{parity_width{1'b0}}, seed};
      enc_q.push_back(ee);
      sent_q.push_back(seed);
      data_valid <= 1'b1;
      data       <= seed;
    end
    @(posedge clk);
    data_valid <= 1'b0;
    while (loop_q.size() < rand_cases) begin
      @(posedge clk);
    end

    // Encoded words straight back into the decoder
    for (int k = 0; k < rand_cases; k++) begin
      @(posedge clk);
      cw            = loop_q.pop_front();
      de.due        = cycle + 3;
      de.check_data = 1'b1;
      de.syndrome   = '0;
      de.data       = sent_q.pop_front();
      de.status     = ecc_ok;
      dec_q.push_back(de);
      rcv_valid    <= 1'b1;
      rcv_codeword <= cw;
    end
    @(posedge clk);
    rcv_valid <= 1'b0;
    wait_drained();
    if (ce_count !== '0 || due_count !== '0 || first_err_valid !== 1'b0) begin
      $display("The error log recorded an event during clean round trips");
      run_errors++;
    end

    $display("Cases: %0d from file, %0d random; errors: %0d in outputs, %0d in log checks",
             num_cases, rand_cases, stream_errors, run_errors);
    if (stream_errors == 0 && run_errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

//--- tests/secded_cases.txt
// data check_bits flip_mask status, status 0 ok, 1 corrected, 2 uncorrectable
// check_bits is the encoder output for data, flip_mask is XORed onto the codeword
00000000 00 0000000000 0
ffffffff 3f 0000000000 0
00000003 0c 0000000000 0
00010001 11 0000000000 0
00000000 00 0000000001 1
ffffffff 3f 0000000002 1
00000001 07 0000000004 1
80000000 38 0000000008 1
00000000 00 0000000010 1
ffffffff 3f 0000000020 1
00000001 07 0000000040 1
80000000 38 0000000080 1
00000000 00 0000000100 1
ffffffff 3f 0000000200 1
00000001 07 0000000400 1
80000000 38 0000000800 1
00000000 00 0000001000 1
ffffffff 3f 0000002000 1
00000001 07 0000004000 1
80000000 38 0000008000 1
00000000 00 0000010000 1
ffffffff 3f 0000020000 1
00000001 07 0000040000 1
80000000 38 0000080000 1
00000000 00 0000100000 1
ffffffff 3f 0000200000 1
00000001 07 0000400000 1
80000000 38 0000800000 1
00000000 00 0001000000 1
ffffffff 3f 0002000000 1
00000001 07 0004000000 1
80000000 38 0008000000 1
00000000 00 0010000000 1
ffffffff 3f 0020000000 1
00000001 07 0040000000 1
80000000 38 0080000000 1
00000000 00 0100000000 1
ffffffff 3f 0200000000 1
00000001 07 0400000000 1
80000000 38 0800000000 1
00000000 00 1000000000 1
ffffffff 3f 2000000000 1
00000001 07 4000000000 1
00000000 00 0000000003 2
ffffffff 3f 0100000001 2
00000001 07 6000000000 2
80000000 38 0080000001 2

//--- project.f
verilog/secded_pkg.sv
verilog/secded_encoder.sv
verilog/secded_syndrome.sv
verilog/secded_corrector.sv
verilog/ecc_error_log.sv
verilog/secded_top.sv
tests/secded_tb.sv

//--- Makefile
TOOL       = verilator
FLAGS      = --binary --timing
LINT_FLAGS = --lint-only --timing
TOP        = secded_tb
FILELIST   = project.f
OBJDIR     = obj_dir
PASS_MSG   = Verification passed

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJDIR)/$(TOP): $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR) -o $(TOP)

# Pass only when the pass message shows up as a line of its own
sim: $(OBJDIR)/$(TOP)
	@out="$$(./$(OBJDIR)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
